//--- vlog.f
rtl/bp_pkg.sv
rtl/bht_port_if.sv
rtl/bht_storage.sv
rtl/bht_lookup.sv
rtl/branch_resolve.sv
rtl/flush_ctrl.sv
rtl/next_pc_select.sv
rtl/branch_predict_unit.sv
bench/tb_branch_predict_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --timescale 1ns/1ps \
	--top-module tb_branch_predict_unit -f vlog.f -o tb_sim; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Simulation passed" "$log"; then
	echo "RESULT: PASS"
	exit 0
else
	echo "RESULT: FAIL"
	exit 1
fi

//--- bench/tb_branch_predict_unit.sv
`default_nettype none

module tb_branch_predict_unit;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_tests = 6;
	// 200 cycles per test plus the reset cycles
	localparam int watchdog_cycles = num_tests * 200 + 5;

	logic CLK;
	logic nrst;
	logic en;
	logic stall;
	logic isr_running;
	logic [9:0] if_pc;
	logic [9:0] id_pc;
	logic [9:0] id_target;
	logic id_is_jump;
	logic id_is_btype;
	logic [9:0] exe_pc;
	logic exe_z;
	logic exe_less;
	logic [5:0] exe_btype;
	logic if_prediction;
	logic [9:0] if_pbt;
	logic [1:0] correction;
	logic [9:0] exe_pbt;
	logic [9:0] exe_cni;
	logic flush;
	logic jump_in_bht;
	logic [9:0] next_pc;

	// reference copy of the table indexed by set * 4 + way
	logic ref_valid [64];
	logic [6:0] ref_tag [64];
	logic [9:0] ref_tgt [64];
	logic [1:0] ref_ctr [64];
	logic [1:0] ref_fifo [16];
	// flush extension of the reference
	logic ref_ext;

	branch_predict_unit dut_i (
		.CLK(CLK), .nrst(nrst), .en(en), .stall(stall), .isr_running(isr_running),
		.if_pc(if_pc), .id_pc(id_pc), .id_target(id_target),
		.id_is_jump(id_is_jump), .id_is_btype(id_is_btype),
		.exe_pc(exe_pc), .exe_z(exe_z), .exe_less(exe_less), .exe_btype(exe_btype),
		.if_prediction(if_prediction), .if_pbt(if_pbt), .correction(correction),
		.exe_pbt(exe_pbt), .exe_cni(exe_cni), .flush(flush),
		.jump_in_bht(jump_in_bht), .next_pc(next_pc)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	initial begin
		#(watchdog_cycles * 10);
		$display("watchdog expired before the tests finished");
		$display("Simulation failed");
		$fatal(1);
	end

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	// way that holds {isr, pc[9:4]} in set pc[3:0] or -1 on a miss
	function automatic int find_way(input logic [9:0] pc, input logic isr);
		int idx;
		for (int w = 0; w < 4; w++) begin
			idx = int'(pc[3:0]) * 4 + w;
			if (ref_valid[idx] && ref_tag[idx] == {isr, pc[9:4]}) begin
				return w;
			end
		end
		return -1;
	endfunction

	// taken rule per branch type
	function automatic logic outcome(input logic [5:0] btype, input logic z, input logic less);
		case (btype)
			6'b100000: return z;
			6'b010000: return !z;
			6'b001000: return less;
			6'b000100: return !less;
			6'b000010: return less;
			6'b000001: return !less;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic exe_mispredict();
		int w;
		w = find_way(exe_pc, isr_running);
		if (exe_btype == 6'd0 || w < 0) begin
			return 1'b0;
		end
		// fetch guessed the counter msb
		return ref_ctr[int'(exe_pc[3:0]) * 4 + w][1] != outcome(exe_btype, exe_z, exe_less);
	endfunction

	function automatic logic [9:0] plus_one(input logic [9:0] pc);
		return pc + 10'd1;
	endfunction

	// random pc whose tag is not in the table
	function automatic logic [9:0] free_pc(input logic isr);
		logic [9:0] pc;
		pc = 10'($urandom);
		while (find_way(pc, isr) >= 0) begin
			pc = 10'($urandom);
		end
		return pc;
	endfunction

	////////////////////////////////////////////////////////////
	// checks and clocking
	////////////////////////////////////////////////////////////

	task automatic compare_value(input string name, input logic [9:0] got, input logic [9:0] exp);
		if (got !== exp) begin
			$display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// every combinational output against the reference
	task automatic match_model();
		int iw;
		int ew;
		int ii;
		int ei;
		logic pred;
		logic mis;
		logic [1:0] corr;
		logic [9:0] pbt;
		logic [9:0] xpbt;
		logic [9:0] xcni;
		logic [9:0] npc;
		iw = find_way(if_pc, isr_running);
		ii = int'(if_pc[3:0]) * 4 + (iw < 0 ? 0 : iw);
		pred = (iw >= 0) ? ref_ctr[ii][1] : 1'b0;
		pbt = (iw >= 0) ? ref_tgt[ii] : 10'd0;
		ew = find_way(exe_pc, isr_running);
		ei = int'(exe_pc[3:0]) * 4 + (ew < 0 ? 0 : ew);
		mis = exe_mispredict();
		if (!mis) begin
			corr = 2'd0;
		end else begin
			corr = outcome(exe_btype, exe_z, exe_less) ? 2'd3 : 2'd2;
		end
		xpbt = (ew >= 0) ? ref_tgt[ei] : 10'd0;
		// stored tag and set plus one with a zero tag on a miss
		xcni = (ew >= 0) ? plus_one(exe_pc) : plus_one({6'd0, exe_pc[3:0]});
		if (corr == 2'd3) begin
			npc = xpbt;
		end else if (corr == 2'd2) begin
			npc = xcni;
		end else begin
			npc = pred ? pbt : plus_one(if_pc);
		end
		compare_value("if_prediction", 10'(if_prediction), 10'(pred));
		compare_value("if_pbt", if_pbt, pbt);
		compare_value("correction", 10'(correction), 10'(corr));
		compare_value("exe_pbt", exe_pbt, xpbt);
		compare_value("exe_cni", exe_cni, xcni);
		compare_value("next_pc", next_pc, npc);
		compare_value("flush", 10'(flush), 10'(mis || ref_ext));
		compare_value("jump_in_bht", 10'(jump_in_bht),
			10'(id_is_jump && find_way(id_pc, isr_running) >= 0));
	endtask

	task automatic settle();
		#1;
	endtask

	// check this cycle and then move the reference across the rising edge
	task automatic step();
		int idw;
		int ew;
		int ei;
		int s;
		int idx;
		logic install;
		logic mis;
		logic tk;
		#1;
		match_model();
		idw = find_way(id_pc, isr_running);
		ew = find_way(exe_pc, isr_running);
		ei = int'(exe_pc[3:0]) * 4 + (ew < 0 ? 0 : ew);
		s = int'(id_pc[3:0]);
		install = (id_is_btype || id_is_jump) && idw < 0;
		mis = exe_mispredict();
		tk = outcome(exe_btype, exe_z, exe_less);
		@(posedge CLK);
		if (en && !stall) begin
			if (install) begin
				idx = s * 4 + int'(ref_fifo[s]);
				ref_valid[idx] = 1'b1;
				ref_tag[idx] = {isr_running, id_pc[9:4]};
				ref_tgt[idx] = id_target;
				ref_ctr[idx] = id_is_jump ? 2'd3 : 2'd1;
				ref_fifo[s] = ref_fifo[s] + 2'd1;
			end else if (exe_btype != 6'd0 && ew >= 0) begin
				// counter saturates at both ends
				if (tk && ref_ctr[ei] != 2'd3) begin
					ref_ctr[ei] = ref_ctr[ei] + 2'd1;
				end else if (!tk && ref_ctr[ei] != 2'd0) begin
					ref_ctr[ei] = ref_ctr[ei] - 2'd1;
				end
			end
		end
		if (en) begin
			ref_ext = mis || (id_is_jump && idw < 0);
		end
		@(negedge CLK);
	endtask

	task automatic drive_idle();
		en = 1'b1;
		stall = 1'b0;
		id_is_jump = 1'b0;
		id_is_btype = 1'b0;
		exe_btype = 6'd0;
		exe_z = 1'b0;
		exe_less = 1'b0;
	endtask

	task automatic install_branch(input logic [9:0] pc, input logic [9:0] tgt);
		id_pc = pc;
		id_target = tgt;
		id_is_btype = 1'b1;
		step();
		drive_idle();
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////

	task automatic reset_misses();
		drive_idle();
		for (int i = 0; i < 32; i++) begin
			if_pc = 10'($urandom);
			settle();
			compare_value("if_prediction", 10'(if_prediction), 10'd0);
			compare_value("next_pc", next_pc, plus_one(if_pc));
			compare_value("flush", 10'(flush), 10'd0);
			compare_value("jump_in_bht", 10'(jump_in_bht), 10'd0);
			step();
		end
	endtask

	task automatic install_and_jump();
		logic [9:0] br_pc;
		logic [9:0] br_tgt;
		logic [9:0] jmp_pc;
		logic [9:0] jmp_tgt;
		drive_idle();
		isr_running = 1'b0;
		br_pc = free_pc(1'b0);
		br_tgt = 10'($urandom);
		install_branch(br_pc, br_tgt);
		if_pc = br_pc;
		settle();
		compare_value("if_pbt", if_pbt, br_tgt);
		compare_value("if_prediction", 10'(if_prediction), 10'd0);
		step();
		// jump installs strongly taken and flushes only in the next cycle
		jmp_pc = free_pc(1'b0);
		jmp_tgt = 10'($urandom);
		id_pc = jmp_pc;
		id_target = jmp_tgt;
		id_is_jump = 1'b1;
		settle();
		compare_value("flush", 10'(flush), 10'd0);
		step();
		drive_idle();
		if_pc = jmp_pc;
		settle();
		compare_value("flush", 10'(flush), 10'd1);
		compare_value("if_prediction", 10'(if_prediction), 10'd1);
		compare_value("next_pc", next_pc, jmp_tgt);
		step();
		settle();
		compare_value("flush", 10'(flush), 10'd0);
		step();
		// same jump again is found in the table
		id_pc = jmp_pc;
		id_is_jump = 1'b1;
		settle();
		compare_value("jump_in_bht", 10'(jump_in_bht), 10'd1);
		step();
		drive_idle();
		settle();
		compare_value("flush", 10'(flush), 10'd0);
		step();
		// stalled decode writes nothing
		br_pc = free_pc(1'b0);
		id_pc = br_pc;
		id_target = 10'($urandom);
		id_is_btype = 1'b1;
		stall = 1'b1;
		step();
		drive_idle();
		if_pc = br_pc;
		settle();
		compare_value("if_pbt", if_pbt, 10'd0);
		step();
	endtask

	task automatic taken_training();
		logic [9:0] pc;
		logic [9:0] tgt;
		drive_idle();
		pc = free_pc(1'b0);
		tgt = 10'($urandom);
		install_branch(pc, tgt);
		if_pc = pc;
		step();
		exe_pc = pc;
		exe_btype = 6'b100000;
		exe_z = 1'b1;
		settle();
		compare_value("correction", 10'(correction), 10'd3);
		compare_value("exe_pbt", exe_pbt, tgt);
		compare_value("flush", 10'(flush), 10'd1);
		compare_value("next_pc", next_pc, tgt);
		step();
		drive_idle();
		settle();
		compare_value("flush", 10'(flush), 10'd1);
		compare_value("if_prediction", 10'(if_prediction), 10'd1);
		step();
		step();
		// counter climbs to 3 and stays there without a flush
		repeat (3) begin
			exe_btype = 6'b100000;
			exe_z = 1'b1;
			settle();
			compare_value("correction", 10'(correction), 10'd0);
			compare_value("flush", 10'(flush), 10'd0);
			step();
			drive_idle();
			step();
		end
	endtask

	task automatic not_taken_correction();
		logic [9:0] pc;
		drive_idle();
		pc = free_pc(1'b0);
		install_branch(pc, 10'($urandom));
		exe_pc = pc;
		exe_btype = 6'b100000;
		exe_z = 1'b1;
		step();
		// bne with zero set right after the beq is not taken against counter 2
		exe_btype = 6'b010000;
		exe_z = 1'b1;
		settle();
		compare_value("correction", 10'(correction), 10'd2);
		compare_value("exe_cni", exe_cni, plus_one(pc));
		compare_value("next_pc", next_pc, plus_one(pc));
		step();
		drive_idle();
		// the second mispredict keeps flush high one more cycle
		settle();
		compare_value("flush", 10'(flush), 10'd1);
		step();
		// random flags over bne..bgeu with an idle cycle between outcomes
		for (int i = 0; i < 40; i++) begin
			exe_btype = 6'b010000 >> ($urandom % 5);
			exe_z = 1'($urandom);
			exe_less = 1'($urandom);
			step();
			drive_idle();
			step();
		end
	endtask

	task automatic fifo_eviction();
		logic [9:0] pcs [5];
		logic [9:0] tgts [5];
		logic [3:0] s;
		logic [9:0] cand;
		drive_idle();
		s = 4'($urandom);
		for (int i = 0; i < 5; i++) begin
			cand = {6'($urandom), s};
			while (find_way(cand, 1'b0) >= 0) begin
				cand = {6'($urandom), s};
			end
			pcs[i] = cand;
			tgts[i] = 10'($urandom);
			install_branch(cand, tgts[i]);
		end
		// fifth install took the first one's way
		if_pc = pcs[0];
		settle();
		compare_value("if_pbt", if_pbt, 10'd0);
		compare_value("next_pc", next_pc, plus_one(pcs[0]));
		step();
		for (int i = 1; i < 5; i++) begin
			if_pc = pcs[i];
			settle();
			compare_value("if_pbt", if_pbt, tgts[i]);
			step();
		end
	endtask

	task automatic isr_and_exe_miss();
		logic [9:0] pc;
		logic [9:0] tgt;
		logic [9:0] miss_pc;
		int idx;
		drive_idle();
		pc = free_pc(1'b0);
		// set whose pointer sits at way 0, the way a missing exe lookup points at
		while (ref_fifo[pc[3:0]] != 2'd0) begin
			pc = free_pc(1'b0);
		end
		tgt = 10'($urandom);
		// a jump so the entry predicts taken
		id_pc = pc;
		id_target = tgt;
		id_is_jump = 1'b1;
		step();
		drive_idle();
		if_pc = pc;
		settle();
		compare_value("if_pbt", if_pbt, tgt);
		step();
		// interrupt mode is part of the tag
		isr_running = 1'b1;
		settle();
		compare_value("if_pbt", if_pbt, 10'd0);
		compare_value("if_prediction", 10'(if_prediction), 10'd0);
		step();
		isr_running = 1'b0;
		miss_pc = {6'($urandom), pc[3:0]};
		while (find_way(miss_pc, 1'b0) >= 0) begin
			miss_pc = {6'($urandom), pc[3:0]};
		end
		exe_pc = miss_pc;
		exe_btype = 6'b100000;
		exe_z = 1'b1;
		settle();
		compare_value("correction", 10'(correction), 10'd0);
		compare_value("flush", 10'(flush), 10'd0);
		step();
		drive_idle();
		// the whole set must be untouched
		for (int w = 0; w < 4; w++) begin
			idx = int'(pc[3:0]) * 4 + w;
			if (ref_valid[idx]) begin
				isr_running = ref_tag[idx][6];
				if_pc = {ref_tag[idx][5:0], pc[3:0]};
				step();
			end
		end
		isr_running = 1'b0;
		if_pc = miss_pc;
		settle();
		compare_value("if_pbt", if_pbt, 10'd0);
		step();
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(88571));
		nrst = 1'b0;
		en = 1'b1;
		stall = 1'b0;
		isr_running = 1'b0;
		if_pc = 10'd0;
		id_pc = 10'd0;
		id_target = 10'd0;
		id_is_jump = 1'b0;
		id_is_btype = 1'b0;
		exe_pc = 10'd0;
		exe_z = 1'b0;
		exe_less = 1'b0;
		exe_btype = 6'd0;
		for (int i = 0; i < 64; i++) begin
			ref_valid[i] = 1'b0;
			ref_tag[i] = 7'd0;
			ref_tgt[i] = 10'd0;
			ref_ctr[i] = 2'd0;
		end
		for (int i = 0; i < 16; i++) begin
			ref_fifo[i] = 2'd0;
		end
		ref_ext = 1'b0;
		repeat (5) @(posedge CLK);
		@(negedge CLK);
		nrst = 1'b1;
		reset_misses();
		install_and_jump();
		taken_training();
		not_taken_correction();
		fifo_eviction();
		isr_and_exe_miss();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/branch_predict_unit.sv
`default_nettype none

module branch_predict_unit import bp_pkg::*; (
	input wire logic CLK,
	input wire logic nrst,
	input wire logic en,
	input wire logic stall,
	input wire logic isr_running,
	input wire logic [pc_w-1:0] if_pc,
	input wire logic [pc_w-1:0] id_pc,
	input wire logic [pc_w-1:0] id_target,
	input wire logic id_is_jump,
	input wire logic id_is_btype,
	input wire logic [pc_w-1:0] exe_pc,
	input wire logic exe_z,
	input wire logic exe_less,
	input wire logic [5:0] exe_btype,
	output logic if_prediction,
	output logic [pc_w-1:0] if_pbt,
	output logic [1:0] correction,
	output logic [pc_w-1:0] exe_pbt,
	output logic [pc_w-1:0] exe_cni,
	output logic flush,
	output logic jump_in_bht,
	output logic [pc_w-1:0] next_pc
);

	bht_port_if if_port ();
	bht_port_if id_port ();
	bht_port_if exe_port ();

	logic id_install_req;
	logic upd_en;
	logic mispredict;
	logic [1:0] upd_ctr;

	////////////////////////////////////////////////////////////
	// table and its three lookups
	////////////////////////////////////////////////////////////

	// control-flow op in decode that is not in the table yet
	assign id_install_req = (id_is_btype || id_is_jump) && !id_port.hit;

	bht_storage storage_i (
		.CLK(CLK), .nrst(nrst), .en(en), .stall(stall), .isr_running(isr_running),
		.rd_if(if_port), .rd_id(id_port), .rd_exe(exe_port),
		.id_install_req(id_install_req), .id_target(id_target), .id_is_jump(id_is_jump),
		.upd_en(upd_en), .upd_ctr(upd_ctr)
	);

	bht_lookup if_lookup_i (.pc(if_pc), .isr_running(isr_running), .port(if_port));
	bht_lookup id_lookup_i (.pc(id_pc), .isr_running(isr_running), .port(id_port));
	bht_lookup exe_lookup_i (.pc(exe_pc), .isr_running(isr_running), .port(exe_port));

	// fetch prediction straight from the hit entry, zero on a miss
	assign if_prediction = if_port.entry[ctr_hi];
	assign if_pbt = if_port.entry[tgt_hi:tgt_lo];

	////////////////////////////////////////////////////////////
	// execute, flush and next PC
	////////////////////////////////////////////////////////////

	branch_resolve resolve_i (
		.exe_pc(exe_pc), .exe_z(exe_z), .exe_less(exe_less), .exe_btype(exe_btype),
		.exe_hit(exe_port.hit), .exe_entry(exe_port.entry),
		.correction(correction), .exe_pbt(exe_pbt), .exe_cni(exe_cni),
		.upd_en(upd_en), .mispredict(mispredict), .upd_ctr(upd_ctr)
	);

	flush_ctrl flush_i (
		.CLK(CLK), .nrst(nrst), .en(en), .mispredict(mispredict),
		.id_is_jump(id_is_jump), .id_hit(id_port.hit),
		.flush(flush), .jump_in_bht(jump_in_bht)
	);

	next_pc_select npc_i (
		.if_pc(if_pc), .if_pbt(if_pbt), .if_prediction(if_prediction),
		.correction(correction), .exe_pbt(exe_pbt), .exe_cni(exe_cni),
		.next_pc(next_pc)
	);

endmodule

`default_nettype wire

//--- rtl/next_pc_select.sv
`default_nettype none

module next_pc_select import bp_pkg::*; (
	input wire logic [pc_w-1:0] if_pc,
	input wire logic [pc_w-1:0] if_pbt,
	input wire logic if_prediction,
	input wire logic [1:0] correction,
	input wire logic [pc_w-1:0] exe_pbt,
	input wire logic [pc_w-1:0] exe_cni,
	output logic [pc_w-1:0] next_pc
);

	// execute correction overrides the fetch guess
	always_comb begin
		case (correction)
			corr_pbt: next_pc = exe_pbt;
			corr_cni: next_pc = exe_cni;
			default: begin
				if (if_prediction) begin
					next_pc = if_pbt;
				end else begin
					// word addressing, so sequential is plus one
					next_pc = if_pc + pc_w'(1);
				end
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/flush_ctrl.sv
`default_nettype none

module flush_ctrl import bp_pkg::*; (
	input wire logic CLK,
	input wire logic nrst,
	input wire logic en,
	input wire logic mispredict,
	input wire logic id_is_jump,
	input wire logic id_hit,
	output logic flush,
	output logic jump_in_bht
);

	// high in the cycle after a flush source
	logic ext_q;
	logic ext_d;

	// arm on a mispredict or on a jump that is not yet installed
	assign ext_d = mispredict || (id_is_jump && !id_hit);

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			ext_q <= 1'b0;
		end else if (en) begin
			ext_q <= ext_d;
		end
	end

	// a jump install flushes only next cycle while a mispredict flushes now as well
	assign flush = mispredict || ext_q;

	// jump found in table so fetch was already sent to its target
	assign jump_in_bht = id_is_jump && id_hit;

endmodule

`default_nettype wire

//--- rtl/branch_resolve.sv
`default_nettype none

module branch_resolve import bp_pkg::*; (
	input wire logic [pc_w-1:0] exe_pc,
	input wire logic exe_z,
	input wire logic exe_less,
	input wire logic [5:0] exe_btype,
	input wire logic exe_hit,
	input wire logic [entry_w-1:0] exe_entry,
	output logic [1:0] correction,
	output logic [pc_w-1:0] exe_pbt,
	output logic [pc_w-1:0] exe_cni,
	output logic upd_en,
	output logic mispredict
	,
	output logic [1:0] upd_ctr
);

	logic is_br;
	logic taken;
	logic [1:0] ctr;

	// btype is one-hot: beq, bne, blt, bge, bltu, bgeu from msb down
	assign is_br = |exe_btype;
	// the ALU already resolved signed vs unsigned into less
	assign taken = |(exe_btype & {exe_z, !exe_z, exe_less, !exe_less, exe_less, !exe_less});

	assign ctr = exe_entry[ctr_hi:ctr_lo];

	// only a branch that is in the table gets trained or corrected
	assign upd_en = is_br && exe_hit;
	// counter msb is what fetch predicted
	assign mispredict = upd_en && (ctr[1] != taken);

	always_comb begin
		if (!mispredict) begin
			correction = corr_none;
		end else if (taken) begin
			correction = corr_pbt;
		end else begin
			correction = corr_cni;
		end
	end

	assign exe_pbt = exe_entry[tgt_hi:tgt_lo];
	// fall-through address rebuilt from stored tag and set
	assign exe_cni = {exe_entry[tag_hi-1:tag_lo], exe_pc[set_w-1:0]} + pc_w'(1);

	// saturating up/down counter
	always_comb begin
		if (taken) begin
			upd_ctr = (ctr == 2'd3) ? ctr : ctr + 2'd1;
		end else begin
			upd_ctr = (ctr == 2'd0) ? ctr : ctr - 2'd1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/bht_lookup.sv
`default_nettype none

module bht_lookup import bp_pkg::*; (
	input wire logic [pc_w-1:0] pc,
	input wire logic isr_running,
	bht_port_if.lookup port
);

	logic [ways-1:0] match;
	logic [way_w-1:0] way_sel;

	// low bits pick the set, upper bits plus isr mode form the tag
	assign port.set = pc[set_w-1:0];
	assign port.tag = {isr_running, pc[pc_w-1:set_w]};

	// one-hot compare against the valid ways
	always_comb begin
		for (int w = 0; w < ways; w++) begin
			match[w] = port.way_words[w][valid_bit] &&
				(port.way_words[w][tag_hi:tag_lo] == port.tag);
		end
	end

	// encode the matching way
	always_comb begin
		way_sel = '0;
		for (int w = 0; w < ways; w++) begin
			if (match[w]) begin
				way_sel = way_w'(w);
			end
		end
	end

	assign port.hit = |match;
	assign port.hit_way = way_sel;
	// a duplicate tag in the set is treated as no usable entry
	assign port.entry = $onehot(match) ? port.way_words[way_sel] : '0;

endmodule

`default_nettype wire

//--- rtl/bht_storage.sv
`default_nettype none

module bht_storage import bp_pkg::*; (
	input wire logic CLK,
	input wire logic nrst,
	input wire logic en,
	input wire logic stall,
	input wire logic isr_running,
	bht_port_if.tbl rd_if,
	bht_port_if.tbl rd_id,
	bht_port_if.tbl rd_exe,
	input wire logic id_install_req,
	input wire logic [pc_w-1:0] id_target,
	input wire logic id_is_jump,
	input wire logic upd_en,
	input wire logic [1:0] upd_ctr
);

	localparam int idx_w = set_w + way_w;

	// payload of each entry, everything below the valid bit
	logic [entry_w-2:0] mem [sets*ways];
	// valid bits kept apart so that reset only touches these
	logic [sets*ways-1:0] valid_q;
	// per-set FIFO replacement pointer
	logic [way_w-1:0] fifo_q [sets];

	logic install;
	logic [idx_w-1:0] inst_idx;
	logic [idx_w-1:0] upd_idx;
	logic [1:0] inst_ctr;

	////////////////////////////////////////////////////////////
	// read ports
	////////////////////////////////////////////////////////////

	// gathers the four ways of one set into full entry words
	function automatic logic [ways-1:0][entry_w-1:0] set_words(input logic [set_w-1:0] s);
		logic [ways-1:0][entry_w-1:0] words;
		logic [idx_w-1:0] idx;
		for (int w = 0; w < ways; w++) begin
			idx = {s, way_w'(w)};
			words[w] = {valid_q[idx], mem[idx]};
		end
		return words;
	endfunction

	always_comb rd_if.way_words = set_words(rd_if.set);
	always_comb rd_id.way_words = set_words(rd_id.set);
	always_comb rd_exe.way_words = set_words(rd_exe.set);

	////////////////////////////////////////////////////////////
	// writes
	////////////////////////////////////////////////////////////

	// only a decode miss installs, even if the request says otherwise
	assign install = id_install_req && !rd_id.hit;
	// victim slot is wherever the set's pointer sits
	assign inst_idx = {rd_id.set, fifo_q[rd_id.set]};
	assign upd_idx = {rd_exe.set, rd_exe.hit_way};
	// jumps start strongly taken, branches weakly not taken
	assign inst_ctr = id_is_jump ? ctr_st : ctr_wnt;

	// control state: valid bits and FIFO pointers
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			valid_q <= '0;
			for (int s = 0; s < sets; s++) begin
				fifo_q[s] <= '0;
			end
		end else if (en && !stall) begin
			if (install) begin
				valid_q[inst_idx] <= 1'b1;
				// pointer wraps after way 3
				fifo_q[rd_id.set] <= fifo_q[rd_id.set] + way_w'(1);
			end
		end
	end

	// payload, install wins over a counter update in the same cycle
	always_ff @(posedge CLK) begin
		if (en && !stall) begin
			if (install) begin
				mem[inst_idx] <= {isr_running, rd_id.tag[tag_w-1:0], id_target, inst_ctr};
			end else if (upd_en) begin
				// target and tag stay, only the counter moves
				mem[upd_idx][ctr_hi:ctr_lo] <= upd_ctr;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/bht_port_if.sv
`default_nettype none

interface bht_port_if import bp_pkg::*; ();

	// lookup side: set index and {isr, pc tag}
	logic [set_w-1:0] set;
	logic [tag_w:0] tag;
	// table side: all four ways of the addressed set
	logic [ways-1:0][entry_w-1:0] way_words;
	// lookup result, entry is zero on a miss or a multi-hit
	logic hit;
	logic [way_w-1:0] hit_way;
	logic [entry_w-1:0] entry;

	modport tbl (input set, tag, hit, hit_way, entry, output way_words);
	modport lookup (output set, tag, hit, hit_way, entry, input way_words);

endinterface

`default_nettype wire

//--- rtl/bp_pkg.sv
`default_nettype none

package bp_pkg;

	////////////////////////////////////////////////////////////
	// table geometry
	////////////////////////////////////////////////////////////

	// word PC, split as {tag, set}
	localparam int pc_w  = 10;
	localparam int set_w = 4;
	localparam int tag_w = 6;
	localparam int way_w = 2;
	localparam int ways  = 4;
	localparam int sets  = 16;

	////////////////////////////////////////////////////////////
	// entry word layout
	////////////////////////////////////////////////////////////

	// {valid, isr bit, pc tag, target, counter}
	localparam int entry_w   = 20;
	localparam int valid_bit = 19;
	// tag_hi is the interrupt-mode bit
	localparam int tag_hi    = 18;
	localparam int tag_lo    = 12;
	localparam int tgt_hi    = 11;
	localparam int tgt_lo    = 2;
	localparam int ctr_hi    = 1;
	localparam int ctr_lo    = 0;

	// install states of the 2-bit counter
	localparam logic [1:0] ctr_wnt = 2'd1;
	localparam logic [1:0] ctr_st  = 2'd3;

	// execute correction codes for the next-PC mux
	localparam logic [1:0] corr_none = 2'd0;
	localparam logic [1:0] corr_cni  = 2'd2;
	localparam logic [1:0] corr_pbt  = 2'd3;

endpackage

`default_nettype wire
